//--- logic/riscv_em_dmem.sv
`timescale 1ns/1ps

module riscv_em_dmem
  import riscv_em_pkg::*;
(
  input  logic               i_riscv_em_clk,
  input  logic               i_riscv_em_memw_m,
  input  riscv_em_storesrc_e i_riscv_em_storesrc_m,
  input  riscv_em_xlen_t     i_riscv_em_addr_m,
  input  riscv_em_xlen_t     i_riscv_em_storedata_m,
  output riscv_em_xlen_t     o_riscv_em_rdword_m
);

  riscv_em_xlen_t              mem_array [RISCV_EM_DMEM_DEPTH];

  logic [RISCV_EM_DMEM_AW-1:0] word_idx;
  logic [2:0]                  byte_off;
  logic [2:0]                  aligned_off;
  logic [5:0]                  lane_shift;
  logic [7:0]                  size_mask;
  logic [7:0]                  byte_en;
  riscv_em_xlen_t              lane_data;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Address split
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Upper bits beyond the array wrap around
  assign word_idx = i_riscv_em_addr_m[3 +: RISCV_EM_DMEM_AW];
  assign byte_off = i_riscv_em_addr_m[2:0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Store lane steering
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Offset is rounded down to the access size
  always_comb
  begin : st_size_proc
    case (i_riscv_em_storesrc_m)
      ST_BYTE:
      begin
        aligned_off = byte_off;
        size_mask   = 8'h01;
      end
      ST_HALF:
      begin
        aligned_off = {byte_off[2:1], 1'b0};
        size_mask   = 8'h03;
      end
      ST_WORD:
      begin
        aligned_off = {byte_off[2], 2'b00};
        size_mask   = 8'h0f;
      end
      default:
      begin
        aligned_off = 3'd0;
        size_mask   = 8'hff;
      end
    endcase
  end

  assign lane_shift = {aligned_off, 3'b000};
  assign byte_en    = size_mask << aligned_off;
  assign lane_data  = i_riscv_em_storedata_m << lane_shift;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Array
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Only enabled lanes change and the rest of the word is kept
  always_ff @(posedge i_riscv_em_clk)
  begin : dmem_write_proc
    if (i_riscv_em_memw_m)
    begin
      for (int b = 0; b < 8; b++)
      begin
        if (byte_en[b])
        begin
          mem_array[word_idx][b*8 +: 8] <= lane_data[b*8 +: 8];
        end
      end
    end
  end

  // Whole doubleword goes out and the result selector picks the field
  assign o_riscv_em_rdword_m = mem_array[word_idx];

endmodule

//--- logic/riscv_em_mem_stage.sv
`timescale 1ns/1ps

module riscv_em_mem_stage
  import riscv_em_pkg::*;
(
  input  logic              i_riscv_em_clk,
  input  logic              i_riscv_em_rst,

  // From the execute stage
  input  riscv_em_ctrl_t    i_riscv_em_ctrl_e,
  input  riscv_em_data_t    i_riscv_em_data_e,

  // Toward the MEM/WB register
  output logic              o_riscv_em_regw_m,
  output riscv_em_regaddr_t o_riscv_em_rdaddr_m,
  output riscv_em_xlen_t    o_riscv_em_wbdata_m,

  // Trace
  output riscv_em_opcode_t  o_riscv_em_opcode_m,
  output riscv_em_inst_t    o_riscv_em_inst_m,
  output riscv_em_cinst_t   o_riscv_em_cinst_m
);

  riscv_em_ctrl_t ctrl_m;
  riscv_em_data_t data_m;
  riscv_em_xlen_t rdword_m;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // EX/MEM register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  riscv_em_ppreg u_ppreg (
    .i_riscv_em_clk    (i_riscv_em_clk),
    .i_riscv_em_rst    (i_riscv_em_rst),
    .i_riscv_em_ctrl_e (i_riscv_em_ctrl_e),
    .i_riscv_em_data_e (i_riscv_em_data_e),
    .o_riscv_em_ctrl_m (ctrl_m),
    .o_riscv_em_data_m (data_m)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Data memory
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // ALU result carries the effective address
  riscv_em_dmem u_dmem (
    .i_riscv_em_clk         (i_riscv_em_clk),
    .i_riscv_em_memw_m      (ctrl_m.memw),
    .i_riscv_em_storesrc_m  (ctrl_m.storesrc),
    .i_riscv_em_addr_m      (data_m.result),
    .i_riscv_em_storedata_m (data_m.storedata),
    .o_riscv_em_rdword_m    (rdword_m)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write-back value
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  riscv_em_result_sel u_result_sel (
    .i_riscv_em_rdword_m    (rdword_m),
    .i_riscv_em_byteoff_m   (data_m.result[2:0]),
    .i_riscv_em_memext_m    (ctrl_m.memext),
    .i_riscv_em_resultsrc_m (ctrl_m.resultsrc),
    .i_riscv_em_result_m    (data_m.result),
    .i_riscv_em_pcplus4_m   (data_m.pcplus4),
    .i_riscv_em_imm_m       (data_m.imm),
    .o_riscv_em_wbdata_m    (o_riscv_em_wbdata_m)
  );

  // Fields that just ride along to write-back
  assign o_riscv_em_regw_m   = ctrl_m.regw;
  assign o_riscv_em_rdaddr_m = data_m.rdaddr;
  assign o_riscv_em_opcode_m = data_m.opcode;
  assign o_riscv_em_inst_m   = data_m.inst;
  assign o_riscv_em_cinst_m  = data_m.cinst;

endmodule

//--- logic/riscv_em_pkg.sv
package riscv_em_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [63:0] riscv_em_xlen_t;
  typedef logic [4:0]  riscv_em_regaddr_t;
  typedef logic [6:0]  riscv_em_opcode_t;
  typedef logic [31:0] riscv_em_inst_t;
  typedef logic [15:0] riscv_em_cinst_t;

  // Data memory is 4 KiB, addressed by doubleword
  localparam int RISCV_EM_DMEM_DEPTH = 512;
  localparam int RISCV_EM_DMEM_AW    = 9;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Encodings
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [1:0] {
    RES_ALU     = 2'd0,
    RES_LOAD    = 2'd1,
    RES_PCPLUS4 = 2'd2,
    RES_IMM     = 2'd3
  } riscv_em_resultsrc_e;

  typedef enum logic [1:0] {
    ST_BYTE   = 2'd0,
    ST_HALF   = 2'd1,
    ST_WORD   = 2'd2,
    ST_DOUBLE = 2'd3
  } riscv_em_storesrc_e;

  // Code 7 is unused and behaves as LD_D
  typedef enum logic [2:0] {
    LD_B  = 3'd0,
    LD_H  = 3'd1,
    LD_W  = 3'd2,
    LD_D  = 3'd3,
    LD_BU = 3'd4,
    LD_HU = 3'd5,
    LD_WU = 3'd6
  } riscv_em_memext_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage bundles
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic                memw;
    logic                regw;
    riscv_em_resultsrc_e resultsrc;
    riscv_em_storesrc_e  storesrc;
    riscv_em_memext_e    memext;
  } riscv_em_ctrl_t;

  typedef struct packed {
    riscv_em_xlen_t    pcplus4;
    riscv_em_xlen_t    result;
    riscv_em_xlen_t    storedata;
    riscv_em_regaddr_t rdaddr;
    riscv_em_xlen_t    imm;
    riscv_em_opcode_t  opcode;
    riscv_em_inst_t    inst;
    riscv_em_cinst_t   cinst;
  } riscv_em_data_t;

endpackage

//--- logic/riscv_em_ppreg.sv
`timescale 1ns/1ps

module riscv_em_ppreg
  import riscv_em_pkg::*;
(
  input  logic           i_riscv_em_clk,
  input  logic           i_riscv_em_rst,

  // Execute-stage bundle
  input  riscv_em_ctrl_t i_riscv_em_ctrl_e,
  input  riscv_em_data_t i_riscv_em_data_e,

  // Memory-stage bundle
  output riscv_em_ctrl_t o_riscv_em_ctrl_m,
  output riscv_em_data_t o_riscv_em_data_m
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control fields
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Clearing memw and regw keeps a reset bubble harmless
  always_ff @(posedge i_riscv_em_clk or posedge i_riscv_em_rst)
  begin : em_ctrl_proc
    if (i_riscv_em_rst)
    begin
      o_riscv_em_ctrl_m <= '0;
    end
    else
    begin
      o_riscv_em_ctrl_m <= i_riscv_em_ctrl_e;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Data fields
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Zero after reset so the traced fields read clean
  always_ff @(posedge i_riscv_em_clk or posedge i_riscv_em_rst)
  begin : em_data_proc
    if (i_riscv_em_rst)
    begin
      o_riscv_em_data_m <= '0;
    end
    else
    begin
      o_riscv_em_data_m <= i_riscv_em_data_e;
    end
  end

endmodule

//--- logic/riscv_em_result_sel.sv
`timescale 1ns/1ps

module riscv_em_result_sel
  import riscv_em_pkg::*;
(
  input  riscv_em_xlen_t      i_riscv_em_rdword_m,
  input  logic [2:0]          i_riscv_em_byteoff_m,
  input  riscv_em_memext_e    i_riscv_em_memext_m,
  input  riscv_em_resultsrc_e i_riscv_em_resultsrc_m,
  input  riscv_em_xlen_t      i_riscv_em_result_m,
  input  riscv_em_xlen_t      i_riscv_em_pcplus4_m,
  input  riscv_em_xlen_t      i_riscv_em_imm_m,
  output riscv_em_xlen_t      o_riscv_em_wbdata_m
);

  logic [2:0]     aligned_off;
  riscv_em_xlen_t field;
  riscv_em_xlen_t load_data;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Load field extraction
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Same rounding as the store side
  always_comb
  begin : ld_align_proc
    case (i_riscv_em_memext_m)
      LD_B, LD_BU: aligned_off = i_riscv_em_byteoff_m;
      LD_H, LD_HU: aligned_off = {i_riscv_em_byteoff_m[2:1], 1'b0};
      LD_W, LD_WU: aligned_off = {i_riscv_em_byteoff_m[2], 2'b00};
      default:     aligned_off = 3'd0;
    endcase
  end

  // Addressed field lands in the low bits
  assign field = i_riscv_em_rdword_m >> {aligned_off, 3'b000};

  always_comb
  begin : ld_ext_proc
    case (i_riscv_em_memext_m)
      LD_B:    load_data = {{56{field[7]}}, field[7:0]};
      LD_H:    load_data = {{48{field[15]}}, field[15:0]};
      LD_W:    load_data = {{32{field[31]}}, field[31:0]};
      LD_BU:   load_data = {56'd0, field[7:0]};
      LD_HU:   load_data = {48'd0, field[15:0]};
      LD_WU:   load_data = {32'd0, field[31:0]};
      // LD_D and the spare code
      default: load_data = field;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write-back source
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb
  begin : wb_sel_proc
    o_riscv_em_wbdata_m = i_riscv_em_result_m;
    case (i_riscv_em_resultsrc_m)
      RES_LOAD:    o_riscv_em_wbdata_m = load_data;
      RES_PCPLUS4: o_riscv_em_wbdata_m = i_riscv_em_pcplus4_m;
      RES_IMM:     o_riscv_em_wbdata_m = i_riscv_em_imm_m;
      default:     o_riscv_em_wbdata_m = i_riscv_em_result_m;
    endcase
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the EX/MEM testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module riscv_em_tb \
  -f sources.f \
  -o sim_riscv_em

sim_out=$(./obj_dir/sim_riscv_em)
echo "$sim_out"

if grep -qx "STATUS: PASS" <<< "$sim_out"
then
  exit 0
else
  exit 1
fi

//--- sources.f
logic/riscv_em_pkg.sv
logic/riscv_em_ppreg.sv
logic/riscv_em_dmem.sv
logic/riscv_em_result_sel.sv
logic/riscv_em_mem_stage.sv
test/riscv_em_tb.sv

//--- test/riscv_em_tb.sv
`timescale 1ns/1ps

module riscv_em_tb
  import riscv_em_pkg::*;
();

  localparam int N_PASS      = 40;
  localparam int N_WB        = 12;
  localparam int N_STLD      = 8;
  localparam int N_EXT       = 64;
  localparam int N_MIX       = 200;
  localparam int PLAN_CYCLES = 2 + 16 + N_PASS + 3 * N_WB + 8 * N_STLD + 1 + N_EXT + N_MIX + 3;
  localparam int WATCHDOG_NS = PLAN_CYCLES * 10 + 500;
  localparam int WIN_BYTES   = 128;

  // Negative bytes, halves and words at several offsets
  localparam riscv_em_xlen_t SIGN_PATTERN = 64'hf0e1_8000_ff7f_80c3;

  logic              riscv_em_clk;
  logic              riscv_em_rst;
  riscv_em_ctrl_t    ctrl_e;
  riscv_em_data_t    data_e;
  logic              regw_m;
  riscv_em_regaddr_t rdaddr_m;
  riscv_em_xlen_t    wbdata_m;
  riscv_em_opcode_t  opcode_m;
  riscv_em_inst_t    inst_m;
  riscv_em_cinst_t   cinst_m;

  // Stimulus now sitting in the M stage, and what the outputs must show for it
  riscv_em_ctrl_t    prev_c;
  riscv_em_data_t    prev_d;
  logic              exp_regw;
  riscv_em_regaddr_t exp_rdaddr;
  riscv_em_xlen_t    exp_wbdata;
  riscv_em_opcode_t  exp_opcode;
  riscv_em_inst_t    exp_inst;
  riscv_em_cinst_t   exp_cinst;

  logic [7:0]        ref_mem [WIN_BYTES];
  logic [31:0]       lfsr;
  int                err_count;
  int                cycle_count;

  riscv_em_mem_stage i_dut (
    .i_riscv_em_clk      (riscv_em_clk),
    .i_riscv_em_rst      (riscv_em_rst),
    .i_riscv_em_ctrl_e   (ctrl_e),
    .i_riscv_em_data_e   (data_e),
    .o_riscv_em_regw_m   (regw_m),
    .o_riscv_em_rdaddr_m (rdaddr_m),
    .o_riscv_em_wbdata_m (wbdata_m),
    .o_riscv_em_opcode_m (opcode_m),
    .o_riscv_em_inst_m   (inst_m),
    .o_riscv_em_cinst_m  (cinst_m)
  );

  initial
  begin : clk_gen
    riscv_em_clk = 1'b0;
    forever
    begin
      #5 riscv_em_clk = ~riscv_em_clk;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
    err_count++;
    $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp_v, act_v);
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[62:0], fb};
    end
    return val;
  endfunction

  // Bits 11 to 7 stay clear so the address falls in the model window
  // Bits above 11 alias back onto the array
  function automatic riscv_em_xlen_t rand_addr(input logic [3:0] dw_mask);
    riscv_em_xlen_t a;
    a       = take_bits(64);
    a[11:7] = 5'd0;
    a[6:3]  = a[6:3] & dw_mask;
    return a;
  endfunction

  function automatic riscv_em_ctrl_t rand_ctrl();
    riscv_em_ctrl_t c;
    c.memw      = 1'(take_bits(1));
    c.regw      = 1'(take_bits(1));
    c.resultsrc = riscv_em_resultsrc_e'(2'(take_bits(2)));
    c.storesrc  = riscv_em_storesrc_e'(2'(take_bits(2)));
    c.memext    = riscv_em_memext_e'(3'(take_bits(3)));
    return c;
  endfunction

  function automatic riscv_em_data_t rand_data();
    riscv_em_data_t d;
    d.pcplus4   = take_bits(64);
    d.result    = take_bits(64);
    d.storedata = take_bits(64);
    d.rdaddr    = riscv_em_regaddr_t'(take_bits(5));
    d.imm       = take_bits(64);
    d.opcode    = riscv_em_opcode_t'(take_bits(7));
    d.inst      = riscv_em_inst_t'(take_bits(32));
    d.cinst     = riscv_em_cinst_t'(take_bits(16));
    return d;
  endfunction

  // Offset rounds down to the access size
  function automatic logic [2:0] align_off(input logic [2:0] off, input int size);
    case (size)
      1:       return off;
      2:       return {off[2:1], 1'b0};
      4:       return {off[2], 2'b00};
      default: return 3'd0;
    endcase
  endfunction

  function automatic riscv_em_xlen_t model_load(input riscv_em_memext_e kind,
                                                input riscv_em_xlen_t addr);
    int             size;
    logic           sgn;
    logic [6:0]     base;
    riscv_em_xlen_t val;
    case (kind)
      LD_B, LD_BU: size = 1;
      LD_H, LD_HU: size = 2;
      LD_W, LD_WU: size = 4;
      default:     size = 8;
    endcase
    sgn  = (kind == LD_B) || (kind == LD_H) || (kind == LD_W);
    base = {addr[6:3], align_off(addr[2:0], size)};
    val  = '0;
    for (int i = 0; i < size; i++)
    begin
      val[i*8 +: 8] = ref_mem[base + 7'(i)];
    end
    if (sgn && val[size*8-1])
    begin
      val = val | (~64'd0 << (size * 8));
    end
    return val;
  endfunction

  task automatic model_store(input riscv_em_storesrc_e kind, input riscv_em_xlen_t addr,
                             input riscv_em_xlen_t data);
    int         size;
    logic [6:0] base;
    case (kind)
      ST_BYTE: size = 1;
      ST_HALF: size = 2;
      ST_WORD: size = 4;
      default: size = 8;
    endcase
    base = {addr[6:3], align_off(addr[2:0], size)};
    for (int i = 0; i < size; i++)
    begin
      ref_mem[base + 7'(i)] = data[i*8 +: 8];
    end
  endtask

  task automatic set_expected();
    exp_regw   = prev_c.regw;
    exp_rdaddr = prev_d.rdaddr;
    exp_opcode = prev_d.opcode;
    exp_inst   = prev_d.inst;
    exp_cinst  = prev_d.cinst;
    case (prev_c.resultsrc)
      RES_LOAD:    exp_wbdata = model_load(prev_c.memext, prev_d.result);
      RES_PCPLUS4: exp_wbdata = prev_d.pcplus4;
      RES_IMM:     exp_wbdata = prev_d.imm;
      default:     exp_wbdata = prev_d.result;
    endcase
  endtask

  // The load in the M stage sees memory before its own cycle's store lands
  task automatic step(input riscv_em_ctrl_t c, input riscv_em_data_t d);
    @(negedge riscv_em_clk);
    set_expected();
    if (prev_c.memw)
    begin
      model_store(prev_c.storesrc, prev_d.result, prev_d.storedata);
    end
    ctrl_e = c;
    data_e = d;
    prev_c = c;
    prev_d = d;
    cycle_count++;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  regw_chk: assert property (@(posedge riscv_em_clk) regw_m === exp_regw)
    else report_mismatch("o_riscv_em_regw_m", 64'(exp_regw), 64'($sampled(regw_m)));
  rdaddr_chk: assert property (@(posedge riscv_em_clk) rdaddr_m === exp_rdaddr)
    else report_mismatch("o_riscv_em_rdaddr_m", 64'(exp_rdaddr), 64'($sampled(rdaddr_m)));
  wbdata_chk: assert property (@(posedge riscv_em_clk) wbdata_m === exp_wbdata)
    else report_mismatch("o_riscv_em_wbdata_m", exp_wbdata, $sampled(wbdata_m));
  opcode_chk: assert property (@(posedge riscv_em_clk) opcode_m === exp_opcode)
    else report_mismatch("o_riscv_em_opcode_m", 64'(exp_opcode), 64'($sampled(opcode_m)));
  inst_chk: assert property (@(posedge riscv_em_clk) inst_m === exp_inst)
    else report_mismatch("o_riscv_em_inst_m", 64'(exp_inst), 64'($sampled(inst_m)));
  cinst_chk: assert property (@(posedge riscv_em_clk) cinst_m === exp_cinst)
    else report_mismatch("o_riscv_em_cinst_m", 64'(exp_cinst), 64'($sampled(cinst_m)));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial
  begin : stim_proc
    riscv_em_ctrl_t c;
    riscv_em_data_t d;
    riscv_em_xlen_t a;
    lfsr         = 32'hbeaa_6d9b;
    err_count    = 0;
    cycle_count  = 0;
    prev_c       = '0;
    prev_d       = '0;
    exp_regw     = 1'b0;
    exp_rdaddr   = '0;
    exp_wbdata   = '0;
    exp_opcode   = '0;
    exp_inst     = '0;
    exp_cinst    = '0;
    riscv_em_rst = 1'b1;

    // Busy inputs while in reset, the M stage must still read zero
    ctrl_e       = rand_ctrl();
    data_e       = rand_data();
    repeat (2) @(negedge riscv_em_clk);
    riscv_em_rst = 1'b0;
    ctrl_e       = '0;
    data_e       = '0;

    // Fill the window so every later load reads known bytes
    for (int k = 0; k < 16; k++)
    begin
      c          = '0;
      c.memw     = 1'b1;
      c.storesrc = ST_DOUBLE;
      d          = rand_data();
      d.result   = {d.result[63:12], 5'd0, 4'(k), 3'd0};
      if (k == 0)
      begin
        d.storedata = SIGN_PATTERN;
      end
      step(c, d);
    end

    for (int n = 0; n < N_PASS; n++)
    begin
      c        = rand_ctrl();
      c.memw   = 1'b0;
      d        = rand_data();
      d.result = rand_addr(4'hf);
      step(c, d);
    end

    for (int s = 0; s < 3; s++)
    begin
      for (int n = 0; n < N_WB; n++)
      begin
        c           = rand_ctrl();
        c.memw      = 1'b0;
        c.resultsrc = (s == 0) ? RES_ALU : (s == 1) ? RES_PCPLUS4 : RES_IMM;
        d           = rand_data();
        step(c, d);
      end
    end

    // Each store is read back as a whole doubleword on the next cycle
    for (int s = 0; s < 4; s++)
    begin
      for (int n = 0; n < N_STLD; n++)
      begin
        c           = rand_ctrl();
        c.memw      = 1'b1;
        c.storesrc  = riscv_em_storesrc_e'(2'(s));
        c.resultsrc = RES_ALU;
        d           = rand_data();
        d.result    = rand_addr(4'hf);
        a           = d.result;
        step(c, d);
        c           = rand_ctrl();
        c.memw      = 1'b0;
        c.resultsrc = RES_LOAD;
        c.memext    = LD_D;
        d           = rand_data();
        d.result    = a;
        step(c, d);
      end
    end

    // Doubleword 0 may have been hit by the stores above
    c           = '0;
    c.memw      = 1'b1;
    c.storesrc  = ST_DOUBLE;
    d           = rand_data();
    d.result    = {d.result[63:12], 9'd0, 3'd0};
    d.storedata = SIGN_PATTERN;
    step(c, d);

    // First pass walks every kind over the fixed pattern at doubleword 0
    for (int n = 0; n < N_EXT; n++)
    begin
      c           = rand_ctrl();
      c.memw      = 1'b0;
      c.resultsrc = RES_LOAD;
      d           = rand_data();
      d.result    = rand_addr((n < 8) ? 4'h0 : 4'hf);
      if (n < 8)
      begin
        c.memext = riscv_em_memext_e'(3'(n));
      end
      step(c, d);
    end

    for (int n = 0; n < N_MIX; n++)
    begin
      c        = rand_ctrl();
      d        = rand_data();
      d.result = rand_addr(4'h3);
      step(c, d);
    end

    step('0, '0);
    step('0, '0);
    @(negedge riscv_em_clk);

    $display("Checked %0d cycles with %0d errors", cycle_count, err_count);
    if (err_count == 0)
    begin
      $display("STATUS: PASS");
    end
    else
    begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial
  begin : watchdog_proc
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, the stimulus never finished", WATCHDOG_NS);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule
